/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module qracc_tb -o qracc_sim

run: compile
	@out="$$(./obj_dir/qracc_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

/* bench/qracc_props.sv */
// QRAcc control assertions

module qracc_props (
    input logic       clk,
    input logic       nrst,
    input logic       bus_valid_i,
    input logic       bus_wen_i,
    input logic       bus_ready_i,
    input logic       rd_valid_i,
    input logic       clear_i,
    input logic       busy_i,
    input logic [2:0] state_i,
    input logic       buf_wr_en_i,
    input logic       scaler_wr_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import qracc_pkg::*;

    logic read_accepted;

    assign read_accepted = bus_valid_i && bus_ready_i && !bus_wen_i;

    // Read strobe lags the accepted read by exactly one cycle
    rd_valid_timing: assert property (@(posedge clk) disable iff (!nrst)
        rd_valid_i == $past(read_accepted))
        else $error("rd_valid_o does not follow an accepted read by one cycle");

    ready_needs_busy: assert property (@(posedge clk) disable iff (!nrst)
        !busy_i |-> !bus_ready_i)
        else $error("bus_ready_o high while the core is idle");

    clear_drops_busy: assert property (@(posedge clk) disable iff (!nrst)
        clear_i |=> !busy_i)
        else $error("busy_o still high one cycle after clear_i");

    // Idle state never touches the buffer or the scaler
    idle_no_write: assert property (@(posedge clk) disable iff (!nrst)
        (state_i == 3'(S_IDLE)) |-> (!buf_wr_en_i && !scaler_wr_i))
        else $error("write enable active in the idle state");

endmodule

bind qracc_top qracc_props u_props (
    .clk(clk), .nrst(nrst),
    .bus_valid_i(bus_valid_i), .bus_wen_i(bus_wen_i),
    .bus_ready_i(bus_ready_o), .rd_valid_i(rd_valid_o),
    .clear_i(clear_i), .busy_i(busy_o), .state_i(state_o),
    .buf_wr_en_i(buf_wr_en), .scaler_wr_i(scaler_wr)
);

/* bench/qracc_tb.sv */
// QRAcc directed testbench

`include "qracc_consts.svh"

module qracc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import qracc_pkg::*;

    localparam int WAIT_LIMIT    = 50;
    localparam int COMPUTE_LIMIT = 4000;

    logic       clk;
    logic       nrst;
    logic       bus_valid_i;
    logic       bus_wen_i;
    act_t       bus_data_i;
    shift_t     cfg_shift_i;
    logic       bus_ready_o;
    act_t       rd_data_o;
    logic       rd_valid_o;
    trigger_t   trigger_i;
    logic       clear_i;
    dim_t       cfg_ifmap_dim_i;
    dim_t       cfg_filter_dim_i;
    logic       busy_o;
    logic [2:0] state_o;

    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] lfsr;
    int          ifmap [0:`QRACC_BUF_DEPTH-1];

    qracc_top DUT (.*);

    always #2 clk = ~clk;

    //////////////////////////////
    // Stimulus and model
    //////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic int take_bits(input int nbits);
        int value;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // All-ones filter, then scale, shift and clamp to 8 bits
    function automatic int model_pixel(input int side, input int filt, input int px,
                                       input int py, input int scale, input int shift);
        int sum;
        int value;
        sum = 0;
        for (int fy = 0; fy < filt; fy++) begin
            for (int fx = 0; fx < filt; fx++) begin
                sum += ifmap[(py + fy) * side + px + fx];
            end
        end
        value = (sum * scale) >> shift;
        return (value > 255) ? 255 : value;
    endfunction

    // Each trigger leaves idle for its own state
    function automatic state_t entered_state(input trigger_t trig);
        case (trig)
            TRIG_LOAD_ACTS:   return S_LOADACTS;
            TRIG_LOAD_SCALER: return S_LOADSCALER;
            TRIG_COMPUTE:     return S_COMPUTE;
            TRIG_READ_ACTS:   return S_READACTS;
            default:          return S_IDLE;
        endcase
    endfunction

    //////////////////////////////
    // Bus and control tasks
    //////////////////////////////

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!bus_ready_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bus_ready_o) begin
            $display("%s: timeout, bus_ready_o stayed low", name);
            timeouts++;
        end
    endtask

    task automatic bus_write(input string name, input int data);
        bus_valid_i = 1'b1;
        bus_wen_i   = 1'b1;
        bus_data_i  = act_t'(data);
        wait_ready(name);
        @(negedge clk);
        bus_valid_i = 1'b0;
    endtask

    // Data and strobe are sampled on the falling edge after the transfer
    task automatic bus_read(input string name, input int expected, input int index);
        bus_valid_i = 1'b1;
        bus_wen_i   = 1'b0;
        wait_ready(name);
        @(negedge clk);
        bus_valid_i = 1'b0;
        checks++;
        if (!rd_valid_o) begin
            $display("%s: rd_valid_o missing after read %0d", name, index);
            errors++;
        end else if (rd_data_o !== act_t'(expected)) begin
            $display("mismatch %s result %0d expected %0d actual %0d",
                     name, index, expected, rd_data_o);
            errors++;
        end
    endtask

    task automatic hold_valid_low(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checks++;
            if (rd_valid_o) begin
                $display("%s: rd_valid_o high while the host held valid low", name);
                errors++;
            end
        end
    endtask

    task automatic expect_idle(input string name);
        checks++;
        if (busy_o || bus_ready_o || state_o != 3'(S_IDLE)) begin
            $display("mismatch %s busy/ready/state expected 0/0/%0d actual %b/%b/%0d",
                     name, S_IDLE, busy_o, bus_ready_o, state_o);
            errors++;
        end
    endtask

    task automatic send_trigger(input string name, input trigger_t trig);
        state_t expected;
        expected  = entered_state(trig);
        trigger_i = trig;
        @(negedge clk);
        trigger_i = TRIG_NONE;
        checks++;
        if (!busy_o) begin
            $display("%s: busy_o did not rise after trigger %s", name, trig.name());
            errors++;
        end else if (state_o != 3'(expected)) begin
            $display("mismatch %s state after %s expected %0d actual %0d",
                     name, trig.name(), expected, state_o);
            errors++;
        end
    endtask

    task automatic load_map(input string name, input int side, input int filt,
                            input int data_bits);
        cfg_ifmap_dim_i  = dim_t'(side);
        cfg_filter_dim_i = dim_t'(filt);
        send_trigger(name, TRIG_LOAD_ACTS);
        for (int i = 0; i < side * side; i++) begin
            ifmap[i] = take_bits(data_bits);
            bus_write(name, ifmap[i]);
        end
        expect_idle(name);
    endtask

    task automatic load_scaler(input string name, input int scale, input int shift);
        cfg_shift_i = shift_t'(shift);
        send_trigger(name, TRIG_LOAD_SCALER);
        bus_write(name, scale);
        expect_idle(name);
    endtask

    task automatic run_compute(input string name);
        int n;
        n = 0;
        send_trigger(name, TRIG_COMPUTE);
        while (busy_o && n < COMPUTE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            $display("%s: timeout, busy_o stayed high during compute", name);
            timeouts++;
        end
    endtask

    // A gap of three idle cycles follows every gap_every reads
    task automatic read_results(input string name, input int side, input int filt,
                                input int scale, input int shift, input int gap_every);
        int out;
        out = side - filt + 1;
        send_trigger(name, TRIG_READ_ACTS);
        for (int i = 0; i < out * out; i++) begin
            bus_read(name, model_pixel(side, filt, i % out, i / out, scale, shift), i);
            if (gap_every > 0 && (i % gap_every) == gap_every - 1 && i != out * out - 1) begin
                hold_valid_low(name, 3);
            end
        end
        expect_idle(name);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic reset_state();
        expect_idle("reset");
    endtask

    task automatic conv_basic();
        load_map("conv6x3", 6, 3, 8);
        load_scaler("conv6x3", 3, 5);
        run_compute("conv6x3");
        read_results("conv6x3", 6, 3, 3, 5, 0);
    endtask

    // Binary data keeps some windows below the clamp
    task automatic saturation();
        load_map("saturate", 4, 2, 1);
        load_scaler("saturate", 200, 0);
        run_compute("saturate");
        read_results("saturate", 4, 2, 200, 0, 0);
    endtask

    task automatic read_stall();
        load_map("stall", 5, 2, 8);
        load_scaler("stall", 1, 2);
        run_compute("stall");
        read_results("stall", 5, 2, 1, 2, 2);
    endtask

    task automatic clear_during_load();
        cfg_ifmap_dim_i  = dim_t'(6);
        cfg_filter_dim_i = dim_t'(3);
        send_trigger("clear", TRIG_LOAD_ACTS);
        for (int i = 0; i < 5; i++) begin
            bus_write("clear", take_bits(8));
        end
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
        expect_idle("clear");
        load_map("clear", 7, 3, 8);
        load_scaler("clear", 2, 4);
        run_compute("clear");
        read_results("clear", 7, 3, 2, 4, 0);
    endtask

    task automatic filter_side_one();
        load_map("filter1", 5, 1, 8);
        load_scaler("filter1", 3, 1);
        run_compute("filter1");
        read_results("filter1", 5, 1, 3, 1, 0);
    endtask

    initial begin
        clk              = 1'b0;
        nrst             = 1'b0;
        bus_valid_i      = 1'b0;
        bus_wen_i        = 1'b0;
        bus_data_i       = '0;
        cfg_shift_i      = '0;
        trigger_i        = TRIG_NONE;
        clear_i          = 1'b0;
        cfg_ifmap_dim_i  = '0;
        cfg_filter_dim_i = '0;
        checks           = 0;
        errors           = 0;
        timeouts         = 0;
        lfsr             = 32'h939d;
        repeat (2) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        reset_state();
        conv_basic();
        saturation();
        read_stall();
        clear_during_load();
        filter_side_one();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/activation_buffer.sv */
// Activation buffer

`include "qracc_consts.svh"

module activation_buffer (
    input  logic             clk,
    input  logic             wr_en_i,
    input  qracc_pkg::addr_t wr_addr_i,
    input  qracc_pkg::act_t  wr_data_i,
    input  logic             rd_en_i,
    input  qracc_pkg::addr_t rd_addr_i,
    output qracc_pkg::act_t  rd_data_o
);
    import qracc_pkg::*;

    act_t mem [0:`QRACC_BUF_DEPTH-1];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Data valid one cycle after rd_en_i
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* hdl/qracc_consts.svh */
// QRAcc sizing constants

`ifndef QRACC_CONSTS_SVH
`define QRACC_CONSTS_SVH

// Activation buffer
`define QRACC_BUF_DEPTH  256
`define QRACC_ADDR_BITS  8

// Datapath widths
`define QRACC_ACT_BITS   8
`define QRACC_ACC_BITS   16
`define QRACC_SCALE_BITS 12
`define QRACC_SHIFT_BITS 4

// Map and filter limits
`define QRACC_MAX_DIM    15
`define QRACC_MAX_FILT   4

`endif

/* hdl/qracc_controller.sv */
// QRAcc main controller

module qracc_controller (
    input  logic                clk,
    input  logic                nrst,
    input  qracc_pkg::trigger_t trigger_i,
    input  logic                clear_i,
    input  qracc_pkg::dim_t     cfg_ifmap_dim_i,
    input  qracc_pkg::dim_t     cfg_filter_dim_i,
    input  logic                bus_valid_i,
    input  logic                bus_wen_i,
    input  logic                cnt_done_i,
    input  logic                cnt_rd_en_i,
    input  logic                cnt_win_last_i,
    input  logic                res_valid_i,
    output logic                bus_ready_o,
    output logic                rd_valid_o,
    output logic                buf_wr_en_o,
    output qracc_pkg::addr_t    buf_wr_addr_o,
    output logic                buf_wr_sel_o,
    output logic                host_rd_en_o,
    output qracc_pkg::addr_t    host_rd_addr_o,
    output logic                cnt_start_o,
    output logic                acc_in_valid_o,
    output logic                acc_in_last_o,
    output logic                scaler_wr_o,
    output qracc_pkg::addr_t    ofmap_base_o,
    output logic                busy_o,
    output logic [2:0]          state_o
);
    import qracc_pkg::*;

    state_t state_q;
    state_t state_d;
    dim_t   out_dim;
    addr_t  in_size;
    addr_t  out_size;
    addr_t  act_wr_ptr;
    addr_t  act_rd_ptr;
    addr_t  out_cnt;
    logic   done_seen_q;
    logic   data_write;
    logic   data_read;

    // Output map sits right after the input map
    assign out_dim      = cfg_ifmap_dim_i - cfg_filter_dim_i + dim_t'(1);
    assign in_size      = addr_t'(cfg_ifmap_dim_i) * addr_t'(cfg_ifmap_dim_i);
    assign out_size     = addr_t'(out_dim) * addr_t'(out_dim);
    assign ofmap_base_o = in_size;

    assign bus_ready_o = (state_q == S_LOADACTS) || (state_q == S_LOADSCALER) ||
                         (state_q == S_READACTS);
    assign data_write  = bus_valid_i && bus_ready_o && bus_wen_i;
    assign data_read   = bus_valid_i && bus_ready_o && !bus_wen_i;

    assign busy_o         = (state_q != S_IDLE);
    assign state_o        = state_q;
    assign host_rd_addr_o = act_rd_ptr;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else if (clear_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                case (trigger_i)
                    TRIG_LOAD_ACTS:   state_d = S_LOADACTS;
                    TRIG_LOAD_SCALER: state_d = S_LOADSCALER;
                    TRIG_COMPUTE:     state_d = S_COMPUTE;
                    TRIG_READ_ACTS:   state_d = S_READACTS;
                    default:          state_d = S_IDLE;
                endcase
            end
            S_LOADACTS: begin
                if (data_write && act_wr_ptr == in_size - addr_t'(1)) state_d = S_IDLE;
            end
            S_LOADSCALER: begin
                if (data_write) state_d = S_IDLE;
            end
            S_COMPUTE: begin
                // Last result lands once the counter has finished
                if (res_valid_i && (done_seen_q || cnt_done_i) &&
                    out_cnt == out_size - addr_t'(1)) begin
                    state_d = S_IDLE;
                end
            end
            S_READACTS: begin
                if (data_read && act_rd_ptr == out_size - addr_t'(1)) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Buffer write steering
    always_comb begin
        buf_wr_en_o   = 1'b0;
        buf_wr_addr_o = act_wr_ptr;
        buf_wr_sel_o  = 1'b0;
        host_rd_en_o  = 1'b0;
        scaler_wr_o   = 1'b0;
        case (state_q)
            S_LOADACTS:   buf_wr_en_o = data_write;
            S_LOADSCALER: scaler_wr_o = data_write;
            S_COMPUTE: begin
                buf_wr_en_o   = res_valid_i;
                buf_wr_addr_o = ofmap_base_o + out_cnt;
                buf_wr_sel_o  = 1'b1;
            end
            S_READACTS:   host_rd_en_o = data_read;
            default:      buf_wr_en_o = 1'b0;
        endcase
    end

    //////////////////////////////
    // Pointers
    //////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            act_wr_ptr  <= '0;
            act_rd_ptr  <= '0;
            out_cnt     <= '0;
            done_seen_q <= 1'b0;
        end else if (clear_i) begin
            act_wr_ptr  <= '0;
            act_rd_ptr  <= '0;
            out_cnt     <= '0;
            done_seen_q <= 1'b0;
        end else begin
            if (state_q == S_LOADACTS && data_write) begin
                if (state_d != S_LOADACTS) act_wr_ptr <= '0;
                else act_wr_ptr <= act_wr_ptr + addr_t'(1);
            end
            if (state_q == S_READACTS && data_read) begin
                if (state_d != S_READACTS) act_rd_ptr <= '0;
                else act_rd_ptr <= act_rd_ptr + addr_t'(1);
            end
            if (state_q == S_COMPUTE) begin
                if (cnt_done_i) done_seen_q <= 1'b1;
                if (res_valid_i) out_cnt <= out_cnt + addr_t'(1);
                if (state_d != S_COMPUTE) begin
                    out_cnt     <= '0;
                    done_seen_q <= 1'b0;
                end
            end
        end
    end

    // Start pulse and one-cycle alignment with the buffer read
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cnt_start_o    <= 1'b0;
            acc_in_valid_o <= 1'b0;
            acc_in_last_o  <= 1'b0;
            rd_valid_o     <= 1'b0;
        end else begin
            cnt_start_o    <= !clear_i && state_q == S_IDLE && state_d == S_COMPUTE;
            acc_in_valid_o <= cnt_rd_en_i;
            acc_in_last_o  <= cnt_win_last_i;
            rd_valid_o     <= data_read;
        end
    end

endmodule

/* hdl/qracc_pkg.sv */
// QRAcc shared types

`include "qracc_consts.svh"

package qracc_pkg;

    //////////////////////////////
    // Data vectors
    //////////////////////////////

    typedef logic [`QRACC_ACT_BITS-1:0]   act_t;
    typedef logic [`QRACC_ADDR_BITS-1:0]  addr_t;
    typedef logic [$clog2(`QRACC_MAX_DIM + 1)-1:0] dim_t;
    typedef logic [`QRACC_ACC_BITS-1:0]   acc_t;
    typedef logic [`QRACC_SCALE_BITS-1:0] scale_t;
    typedef logic [`QRACC_SHIFT_BITS-1:0] shift_t;

    //////////////////////////////
    // Control encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        TRIG_NONE        = 3'd0,
        TRIG_LOAD_ACTS   = 3'd1,
        TRIG_LOAD_SCALER = 3'd2,
        TRIG_COMPUTE     = 3'd3,
        TRIG_READ_ACTS   = 3'd4
    } trigger_t;

    typedef enum logic [2:0] {
        S_IDLE       = 3'd0,
        S_LOADACTS   = 3'd1,
        S_LOADSCALER = 3'd2,
        S_COMPUTE    = 3'd3,
        S_READACTS   = 3'd4
    } state_t;

endpackage

/* hdl/qracc_top.sv */
// QRAcc convolution core top

module qracc_top (
    input  logic                clk,
    input  logic                nrst,
    input  logic                bus_valid_i,
    input  logic                bus_wen_i,
    input  qracc_pkg::act_t     bus_data_i,
    input  qracc_pkg::shift_t   cfg_shift_i,
    output logic                bus_ready_o,
    output qracc_pkg::act_t     rd_data_o,
    output logic                rd_valid_o,
    input  qracc_pkg::trigger_t trigger_i,
    input  logic                clear_i,
    input  qracc_pkg::dim_t     cfg_ifmap_dim_i,
    input  qracc_pkg::dim_t     cfg_filter_dim_i,
    output logic                busy_o,
    output logic [2:0]          state_o
);
    import qracc_pkg::*;

    logic   buf_wr_en;
    addr_t  buf_wr_addr;
    logic   buf_wr_sel;
    act_t   buf_wr_data;
    logic   host_rd_en;
    addr_t  host_rd_addr;
    logic   buf_rd_en;
    addr_t  buf_rd_addr;
    addr_t  ofmap_base;
    logic   cnt_start;
    logic   cnt_rd_en;
    addr_t  cnt_rd_addr;
    logic   cnt_win_last;
    logic   cnt_done;
    logic   acc_in_valid;
    logic   acc_in_last;
    logic   scaler_wr;
    logic   res_valid;
    act_t   res;
    scale_t scale;

    // Counter owns the read port during compute, host reads the output map otherwise
    assign buf_rd_en   = (state_o == S_COMPUTE) ? cnt_rd_en : host_rd_en;
    assign buf_rd_addr = (state_o == S_COMPUTE) ? cnt_rd_addr : ofmap_base + host_rd_addr;
    assign buf_wr_data = buf_wr_sel ? res : bus_data_i;
    assign scale       = scale_t'(bus_data_i);

    qracc_controller u_controller (
        .clk(clk), .nrst(nrst),
        .trigger_i(trigger_i), .clear_i(clear_i),
        .cfg_ifmap_dim_i(cfg_ifmap_dim_i), .cfg_filter_dim_i(cfg_filter_dim_i),
        .bus_valid_i(bus_valid_i), .bus_wen_i(bus_wen_i),
        .cnt_done_i(cnt_done), .cnt_rd_en_i(cnt_rd_en),
        .cnt_win_last_i(cnt_win_last), .res_valid_i(res_valid),
        .bus_ready_o(bus_ready_o), .rd_valid_o(rd_valid_o),
        .buf_wr_en_o(buf_wr_en), .buf_wr_addr_o(buf_wr_addr), .buf_wr_sel_o(buf_wr_sel),
        .host_rd_en_o(host_rd_en), .host_rd_addr_o(host_rd_addr),
        .cnt_start_o(cnt_start), .acc_in_valid_o(acc_in_valid), .acc_in_last_o(acc_in_last),
        .scaler_wr_o(scaler_wr), .ofmap_base_o(ofmap_base),
        .busy_o(busy_o), .state_o(state_o)
    );

    window_counter u_window_counter (
        .clk(clk), .nrst(nrst), .start_i(cnt_start),
        .cfg_ifmap_dim_i(cfg_ifmap_dim_i), .cfg_filter_dim_i(cfg_filter_dim_i),
        .rd_en_o(cnt_rd_en), .rd_addr_o(cnt_rd_addr),
        .win_last_o(cnt_win_last), .done_o(cnt_done)
    );

    activation_buffer u_activation_buffer (
        .clk(clk),
        .wr_en_i(buf_wr_en), .wr_addr_i(buf_wr_addr), .wr_data_i(buf_wr_data),
        .rd_en_i(buf_rd_en), .rd_addr_i(buf_rd_addr), .rd_data_o(rd_data_o)
    );

    window_accumulator u_window_accumulator (
        .clk(clk), .nrst(nrst),
        .in_valid_i(acc_in_valid), .in_last_i(acc_in_last), .in_data_i(rd_data_o),
        .scaler_wr_i(scaler_wr), .scale_i(scale), .shift_i(cfg_shift_i),
        .res_valid_o(res_valid), .res_o(res)
    );

endmodule

/* hdl/window_accumulator.sv */
// Window sum with output scaling

`include "qracc_consts.svh"

module window_accumulator (
    input  logic              clk,
    input  logic              nrst,
    input  logic              in_valid_i,
    input  logic              in_last_i,
    input  qracc_pkg::act_t   in_data_i,
    input  logic              scaler_wr_i,
    input  qracc_pkg::scale_t scale_i,
    input  qracc_pkg::shift_t shift_i,
    output logic              res_valid_o,
    output qracc_pkg::act_t   res_o
);
    import qracc_pkg::*;

    localparam int PROD_BITS = `QRACC_ACC_BITS + `QRACC_SCALE_BITS;

    acc_t                 sum_q;
    acc_t                 win_sum;
    scale_t               scale_q;
    shift_t               shift_q;
    logic [PROD_BITS-1:0] prod;
    logic [PROD_BITS-1:0] shifted;
    act_t                 sat;

    // Sum including the element arriving now
    assign win_sum = sum_q + acc_t'(in_data_i);
    assign prod    = PROD_BITS'(win_sum) * PROD_BITS'(scale_q);
    assign shifted = prod >> shift_q;
    // Clamp to 255 when anything spills above the result width
    assign sat     = (|shifted[PROD_BITS-1:`QRACC_ACT_BITS]) ? '1 : act_t'(shifted);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sum_q       <= '0;
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= in_valid_i && in_last_i;
            if (in_valid_i) begin
                sum_q <= in_last_i ? '0 : win_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_last_i) begin
            res_o <= sat;
        end
        if (scaler_wr_i) begin
            scale_q <= scale_i;
            shift_q <= shift_i;
        end
    end

endmodule

/* hdl/window_counter.sv */
// Convolution window address generator

`include "qracc_consts.svh"

module window_counter (
    input  logic             clk,
    input  logic             nrst,
    input  logic             start_i,
    input  qracc_pkg::dim_t  cfg_ifmap_dim_i,
    input  qracc_pkg::dim_t  cfg_filter_dim_i,
    output logic             rd_en_o,
    output qracc_pkg::addr_t rd_addr_o,
    output logic             win_last_o,
    output logic             done_o
);
    import qracc_pkg::*;

    localparam int FILT_BITS = $clog2(`QRACC_MAX_FILT);

    logic                 active_q;
    logic                 done_q;
    logic [FILT_BITS-1:0] fx_q;
    logic [FILT_BITS-1:0] fy_q;
    dim_t                 px_q;
    dim_t                 py_q;
    dim_t                 filt_last;
    dim_t                 out_last;
    dim_t                 row;
    dim_t                 col;
    logic                 fx_end;
    logic                 fy_end;

    assign filt_last = cfg_filter_dim_i - dim_t'(1);
    assign out_last  = cfg_ifmap_dim_i - cfg_filter_dim_i;
    assign fx_end    = (dim_t'(fx_q) == filt_last);
    assign fy_end    = (dim_t'(fy_q) == filt_last);

    // Input pixel under the current window element
    assign row       = py_q + dim_t'(fy_q);
    assign col       = px_q + dim_t'(fx_q);
    assign rd_addr_o = addr_t'(row) * addr_t'(cfg_ifmap_dim_i) + addr_t'(col);

    assign rd_en_o    = active_q;
    assign win_last_o = active_q && fx_end && fy_end;
    assign done_o     = done_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            fx_q     <= '0;
            fy_q     <= '0;
            px_q     <= '0;
            py_q     <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            done_q   <= 1'b0;
            fx_q     <= '0;
            fy_q     <= '0;
            px_q     <= '0;
            py_q     <= '0;
        end else begin
            done_q <= 1'b0;
            if (active_q) begin
                // Filter x innermost, then filter y, then output pixel
                if (!fx_end) begin
                    fx_q <= fx_q + 1'b1;
                end else begin
                    fx_q <= '0;
                    if (!fy_end) begin
                        fy_q <= fy_q + 1'b1;
                    end else begin
                        fy_q <= '0;
                        if (px_q != out_last) begin
                            px_q <= px_q + dim_t'(1);
                        end else begin
                            px_q <= '0;
                            if (py_q != out_last) begin
                                py_q <= py_q + dim_t'(1);
                            end else begin
                                py_q     <= '0;
                                active_q <= 1'b0;
                                done_q   <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/qracc_pkg.sv
hdl/activation_buffer.sv
hdl/window_accumulator.sv
hdl/window_counter.sv
hdl/qracc_controller.sv
hdl/qracc_top.sv
bench/qracc_props.sv
bench/qracc_tb.sv
